/* dw_upsizer_pkg.sv */
// ***************************************************************************
// Data width upsizer shared definitions
// ***************************************************************************
`default_nettype none

package dw_upsizer_pkg;

  localparam int unsigned NarrowDataWidth = 32;
  localparam int unsigned WideDataWidth   = 64;
  localparam int unsigned NarrowStrbWidth = 4;
  localparam int unsigned WideStrbWidth   = 8;
  localparam int unsigned NarrowMaxSize   = 2;
  localparam int unsigned WideMaxSize     = 3;
  localparam int unsigned AddrWidth       = 16;
  localparam int unsigned IdWidth         = 4;

  typedef logic [AddrWidth-1:0]       addr_t;
  typedef logic [IdWidth-1:0]         id_t;
  typedef logic [7:0]                 len_t;
  typedef logic [2:0]                 size_t;
  typedef logic [1:0]                 burst_t;
  typedef logic [3:0]                 cache_t;
  typedef logic [NarrowDataWidth-1:0] narrow_data_t;
  typedef logic [NarrowStrbWidth-1:0] narrow_strb_t;
  typedef logic [WideDataWidth-1:0]   wide_data_t;
  typedef logic [WideStrbWidth-1:0]   wide_strb_t;
  typedef logic [1:0]                 resp_t;

  localparam burst_t BurstFixed = 2'd0;
  localparam burst_t BurstIncr  = 2'd1;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } ax_chan_t;

  typedef struct packed {
    narrow_data_t data;
    narrow_strb_t strb;
    logic         last;
  } narrow_w_chan_t;

  typedef struct packed {
    wide_data_t data;
    wide_strb_t strb;
    logic       last;
  } wide_w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t          id;
    narrow_data_t data;
    resp_t        resp;
    logic         last;
  } narrow_r_chan_t;

  typedef struct packed {
    id_t        id;
    wide_data_t data;
    resp_t      resp;
    logic       last;
  } wide_r_chan_t;

  typedef struct packed {
    ax_chan_t       aw;
    logic           aw_valid;
    narrow_w_chan_t w;
    logic           w_valid;
    logic           b_ready;
    ax_chan_t       ar;
    logic           ar_valid;
    logic           r_ready;
  } narrow_req_t;

  typedef struct packed {
    logic           aw_ready;
    logic           w_ready;
    b_chan_t        b;
    logic           b_valid;
    logic           ar_ready;
    narrow_r_chan_t r;
    logic           r_valid;
  } narrow_resp_t;

  typedef struct packed {
    ax_chan_t     aw;
    logic         aw_valid;
    wide_w_chan_t w;
    logic         w_valid;
    logic         b_ready;
    ax_chan_t     ar;
    logic         ar_valid;
    logic         r_ready;
  } wide_req_t;

  typedef struct packed {
    logic         aw_ready;
    logic         w_ready;
    b_chan_t      b;
    logic         b_valid;
    logic         ar_ready;
    wide_r_chan_t r;
    logic         r_valid;
  } wide_resp_t;

  typedef enum logic {
    ModePass,
    ModeUpsize
  } burst_mode_e;

  typedef enum logic [1:0] {
    WIdle,
    WPass,
    WUpsize
  } w_state_e;

  typedef enum logic [1:0] {
    RIdle,
    RPass,
    RUpsize
  } r_state_e;

  // Clear the address bits below the given size
  function automatic addr_t aligned_addr(addr_t addr, size_t size);
    return addr & ~((addr_t'(1) << size) - addr_t'(1));
  endfunction

  function automatic logic is_modifiable(cache_t cache);
    return cache[1];
  endfunction

  // Address of the following beat of a burst
  function automatic addr_t next_beat_addr(addr_t addr, size_t size, burst_t burst);
    if (burst == BurstFixed) begin
      return addr;
    end
    return aligned_addr(addr, size) + (addr_t'(1) << size);
  endfunction

endpackage

`default_nettype wire

/* dw_burst_planner.sv */
// ***************************************************************************
// Burst planner
// ***************************************************************************
`default_nettype none

module dw_burst_planner
  import dw_upsizer_pkg::*;
(
  input  ax_chan_t    req_i,
  output ax_chan_t    req_o,
  output burst_mode_e mode_o
);

  addr_t start_addr;
  addr_t end_addr;
  logic  upsize;

  // Wide-aligned first and last byte addresses of the burst
  assign start_addr = aligned_addr(req_i.addr, size_t'(WideMaxSize));
  assign end_addr   = aligned_addr(aligned_addr(req_i.addr, req_i.size) +
                                   (addr_t'(req_i.len) << req_i.size),
                                   size_t'(WideMaxSize));

  // Single beats gain nothing from repacking
  assign upsize = (req_i.burst == BurstIncr) && is_modifiable(req_i.cache) &&
                  (req_i.len != '0);

  always_comb begin
    req_o  = req_i;
    mode_o = ModePass;
    if (upsize) begin
      req_o.len  = len_t'((end_addr - start_addr) >> WideMaxSize);
      req_o.size = size_t'(WideMaxSize);
      mode_o     = ModeUpsize;
    end
  end

  always_comb begin
    a_size_fits: assert (req_o.size <= size_t'(WideMaxSize))
      else $error("planned size exceeds the wide port");
  end

endmodule

`default_nettype wire

/* dw_write_upsizer.sv */
// ***************************************************************************
// Write path upsizer
// ***************************************************************************
`default_nettype none

module dw_write_upsizer
  import dw_upsizer_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ax_chan_t       aw_i,
  input  logic           aw_valid_i,
  output logic           aw_ready_o,
  input  narrow_w_chan_t w_i,
  input  logic           w_valid_i,
  output logic           w_ready_o,
  output ax_chan_t       mst_aw_o,
  output logic           mst_aw_valid_o,
  input  logic           mst_aw_ready_i,
  output wide_w_chan_t   mst_w_o,
  output logic           mst_w_valid_o,
  input  logic           mst_w_ready_i
);

  w_state_e     w_state_q, w_state_d;
  logic         init_q;
  ax_chan_t     aw_q, aw_d;
  logic         aw_valid_q, aw_valid_d;
  size_t        orig_size_q, orig_size_d;
  len_t         len_q, len_d;
  addr_t        addr_q, addr_d;
  wide_w_chan_t w_q, w_d;
  logic         w_valid_q, w_valid_d;

  ax_chan_t     aw_planned;
  burst_mode_e  aw_mode;
  addr_t        addr_next;
  addr_t        beat_base;
  logic [2:0]   lane_lo;
  logic [2:0]   lane_hi;
  logic         crosses;

  dw_burst_planner i_planner (
    .req_i  (aw_i),
    .req_o  (aw_planned),
    .mode_o (aw_mode)
  );

  assign addr_next = next_beat_addr(addr_q, orig_size_q, aw_q.burst);
  assign crosses   = aligned_addr(addr_next, size_t'(WideMaxSize)) !=
                     aligned_addr(addr_q, size_t'(WideMaxSize));

  // Byte window of the current narrow beat
  assign beat_base = aligned_addr(addr_q, orig_size_q);
  assign lane_lo   = {1'b0, addr_q[1:0]};
  assign lane_hi   = {1'b0, beat_base[1:0]} + (3'd1 << orig_size_q);

  assign aw_ready_o     = init_q && (w_state_q == WIdle);
  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_valid_q;
  assign mst_w_o        = w_q;
  assign mst_w_valid_o  = w_valid_q;

  // Narrow data only after the wide AW went out, and never past the last beat
  assign w_ready_o = (w_state_q != WIdle) && !aw_valid_q &&
                     (!w_valid_q || (mst_w_ready_i && !w_q.last));

  always_comb begin
    w_state_d   = w_state_q;
    aw_d        = aw_q;
    aw_valid_d  = aw_valid_q;
    orig_size_d = orig_size_q;
    len_d       = len_q;
    addr_d      = addr_q;
    w_d         = w_q;
    w_valid_d   = w_valid_q;

    if (aw_valid_q && mst_aw_ready_i) begin
      aw_valid_d = 1'b0;
    end

    // Wide beat taken, start a fresh word
    if (w_valid_q && mst_w_ready_i) begin
      w_d       = '0;
      w_valid_d = 1'b0;
      if (w_q.last) begin
        w_state_d = WIdle;
      end
    end

    if (w_valid_i && w_ready_o) begin
      for (int n = 0; n < NarrowStrbWidth; n++) begin
        if (3'(n) >= lane_lo && 3'(n) < lane_hi) begin
          w_d.data[8*n + NarrowDataWidth*int'(addr_q[NarrowMaxSize]) +: 8] =
            w_i.data[8*n +: 8];
          w_d.strb[n + NarrowStrbWidth*int'(addr_q[NarrowMaxSize])] = w_i.strb[n];
        end
      end
      w_d.last = (len_q == '0);
      len_d    = len_q - 1'b1;
      addr_d   = addr_next;
      if (w_state_q == WPass || len_q == '0 || crosses) begin
        w_valid_d = 1'b1;
      end
    end

    if (aw_valid_i && aw_ready_o) begin
      aw_d        = aw_planned;
      aw_valid_d  = 1'b1;
      orig_size_d = aw_i.size;
      len_d       = aw_i.len;
      addr_d      = aw_i.addr;
      w_d         = '0;
      w_valid_d   = 1'b0;
      w_state_d   = (aw_mode == ModeUpsize) ? WUpsize : WPass;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q  <= WIdle;
      init_q     <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
    end else begin
      w_state_q  <= w_state_d;
      init_q     <= 1'b1;
      aw_valid_q <= aw_valid_d;
      w_valid_q  <= w_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    aw_q        <= aw_d;
    orig_size_q <= orig_size_d;
    len_q       <= len_d;
    addr_q      <= addr_d;
    w_q         <= w_d;
  end

  a_w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o |-> !mst_aw_valid_o);

endmodule

`default_nettype wire

/* dw_read_upsizer.sv */
// ***************************************************************************
// Read path upsizer
// ***************************************************************************
`default_nettype none

module dw_read_upsizer
  import dw_upsizer_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ax_chan_t       ar_i,
  input  logic           ar_valid_i,
  output logic           ar_ready_o,
  output narrow_r_chan_t r_o,
  output logic           r_valid_o,
  input  logic           r_ready_i,
  output ax_chan_t       mst_ar_o,
  output logic           mst_ar_valid_o,
  input  logic           mst_ar_ready_i,
  input  wide_r_chan_t   mst_r_i,
  input  logic           mst_r_valid_i,
  output logic           mst_r_ready_o
);

  r_state_e    r_state_q, r_state_d;
  logic        init_q;
  ax_chan_t    ar_q, ar_d;
  logic        ar_valid_q, ar_valid_d;
  size_t       orig_size_q, orig_size_d;
  len_t        len_q, len_d;
  addr_t       addr_q, addr_d;

  ax_chan_t    ar_planned;
  burst_mode_e ar_mode;
  addr_t       addr_next;
  addr_t       beat_base;
  logic [2:0]  lane_lo;
  logic [2:0]  lane_hi;
  logic        crosses;
  logic        r_hs;

  dw_burst_planner i_planner (
    .req_i  (ar_i),
    .req_o  (ar_planned),
    .mode_o (ar_mode)
  );

  assign addr_next = next_beat_addr(addr_q, orig_size_q, ar_q.burst);
  assign crosses   = aligned_addr(addr_next, size_t'(WideMaxSize)) !=
                     aligned_addr(addr_q, size_t'(WideMaxSize));
  assign beat_base = aligned_addr(addr_q, orig_size_q);
  assign lane_lo   = {1'b0, addr_q[1:0]};
  assign lane_hi   = {1'b0, beat_base[1:0]} + (3'd1 << orig_size_q);

  assign ar_ready_o     = init_q && (r_state_q == RIdle);
  assign mst_ar_o       = ar_q;
  assign mst_ar_valid_o = ar_valid_q;

  // R is combinational once the wide AR is out
  assign r_valid_o = (r_state_q != RIdle) && !ar_valid_q && mst_r_valid_i;
  assign r_hs      = r_valid_o && r_ready_i;

  // Release the wide beat after its last narrow slice
  assign mst_r_ready_o = r_hs && (r_state_q == RPass || crosses || len_q == '0);

  always_comb begin
    r_o      = '0;
    r_o.id   = mst_r_i.id;
    r_o.resp = mst_r_i.resp;
    r_o.last = mst_r_i.last && (len_q == '0);
    // Lane steering from the addressed half of the wide word
    for (int n = 0; n < NarrowStrbWidth; n++) begin
      if (3'(n) >= lane_lo && 3'(n) < lane_hi) begin
        r_o.data[8*n +: 8] =
          mst_r_i.data[8*n + NarrowDataWidth*int'(addr_q[NarrowMaxSize]) +: 8];
      end
    end
  end

  always_comb begin
    r_state_d   = r_state_q;
    ar_d        = ar_q;
    ar_valid_d  = ar_valid_q;
    orig_size_d = orig_size_q;
    len_d       = len_q;
    addr_d      = addr_q;

    if (ar_valid_q && mst_ar_ready_i) begin
      ar_valid_d = 1'b0;
    end

    if (r_hs) begin
      len_d  = len_q - 1'b1;
      addr_d = addr_next;
      if (len_q == '0) begin
        r_state_d = RIdle;
      end
    end

    if (ar_valid_i && ar_ready_o) begin
      ar_d        = ar_planned;
      ar_valid_d  = 1'b1;
      orig_size_d = ar_i.size;
      len_d       = ar_i.len;
      addr_d      = ar_i.addr;
      r_state_d   = (ar_mode == ModeUpsize) ? RUpsize : RPass;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_state_q  <= RIdle;
      init_q     <= 1'b0;
      ar_valid_q <= 1'b0;
    end else begin
      r_state_q  <= r_state_d;
      init_q     <= 1'b1;
      ar_valid_q <= ar_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ar_q        <= ar_d;
    orig_size_q <= orig_size_d;
    len_q       <= len_d;
    addr_q      <= addr_d;
  end

  // Wide last is released together with the final narrow beat
  a_r_last_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_r_ready_o |-> (mst_r_i.last == (len_q == '0)));

endmodule

`default_nettype wire

/* dw_upsizer_top.sv */
// ***************************************************************************
// Data width upsizer top
// ***************************************************************************
`default_nettype none

module dw_upsizer_top
  import dw_upsizer_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  narrow_req_t  slv_req_i,
  output narrow_resp_t slv_resp_o,
  output wide_req_t    mst_req_o,
  input  wide_resp_t   mst_resp_i
);

  dw_write_upsizer i_write (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .aw_i           (slv_req_i.aw),
    .aw_valid_i     (slv_req_i.aw_valid),
    .aw_ready_o     (slv_resp_o.aw_ready),
    .w_i            (slv_req_i.w),
    .w_valid_i      (slv_req_i.w_valid),
    .w_ready_o      (slv_resp_o.w_ready),
    .mst_aw_o       (mst_req_o.aw),
    .mst_aw_valid_o (mst_req_o.aw_valid),
    .mst_aw_ready_i (mst_resp_i.aw_ready),
    .mst_w_o        (mst_req_o.w),
    .mst_w_valid_o  (mst_req_o.w_valid),
    .mst_w_ready_i  (mst_resp_i.w_ready)
  );

  dw_read_upsizer i_read (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_i           (slv_req_i.ar),
    .ar_valid_i     (slv_req_i.ar_valid),
    .ar_ready_o     (slv_resp_o.ar_ready),
    .r_o            (slv_resp_o.r),
    .r_valid_o      (slv_resp_o.r_valid),
    .r_ready_i      (slv_req_i.r_ready),
    .mst_ar_o       (mst_req_o.ar),
    .mst_ar_valid_o (mst_req_o.ar_valid),
    .mst_ar_ready_i (mst_resp_i.ar_ready),
    .mst_r_i        (mst_resp_i.r),
    .mst_r_valid_i  (mst_resp_i.r_valid),
    .mst_r_ready_o  (mst_req_o.r_ready)
  );

  // B needs no conversion
  assign slv_resp_o.b       = mst_resp_i.b;
  assign slv_resp_o.b_valid = mst_resp_i.b_valid;
  assign mst_req_o.b_ready  = slv_req_i.b_ready;

endmodule

`default_nettype wire

/* tb_wide_mem.sv */
// ***************************************************************************
// Wide side memory model
// ***************************************************************************
`default_nettype none

module tb_wide_mem
  import dw_upsizer_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       stall_en_i,
  input  wide_req_t  req_i,
  output wide_resp_t resp_o,
  output len_t       aw_len_o,
  output size_t      aw_size_o,
  output len_t       ar_len_o,
  output size_t      ar_size_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]   mem [256];
  integer       seed;
  logic         stall_s;
  ax_chan_t     aw_q;
  ax_chan_t     ar_q;
  ax_chan_t     aw_s;
  ax_chan_t     ar_s;
  wide_w_chan_t w_s;
  addr_t        wr_addr;
  addr_t        wbase;
  addr_t        rd_addr;
  len_t         rd_cnt;
  logic         wr_busy;
  logic         aw_hs;
  logic         w_hs;
  logic         b_hs;
  logic         ar_hs;
  logic         r_hs;

  // Beat address of an AXI burst, FIXED stays put
  function automatic addr_t step_addr(addr_t a, size_t s, burst_t b);
    addr_t lsb;
    lsb = addr_t'(1) << s;
    if (b == BurstFixed) begin
      return a;
    end
    return (a & ~(lsb - addr_t'(1))) + lsb;
  endfunction

  function automatic logic random_stall();
    return stall_s && (($random(seed) & 3) == 0);
  endfunction

  // Full wide word around the current read address
  task automatic load_r_beat();
    addr_t base;
    base = rd_addr & ~addr_t'(7);
    for (int n = 0; n < WideStrbWidth; n++) begin
      resp_o.r.data[8*n +: 8] = mem[base[7:0] + 8'(n)];
    end
    resp_o.r.id   = ar_q.id;
    resp_o.r.resp = '0;
    resp_o.r.last = (rd_cnt == ar_q.len);
  endtask

  initial begin
    seed      = 64;
    resp_o    = '0;
    wr_busy   = 1'b0;
    aw_len_o  = '0;
    aw_size_o = '0;
    ar_len_o  = '0;
    ar_size_o = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'hA5;
    end
    forever begin
      // Handshakes are taken where all signals are settled
      @(negedge clk_i);
      aw_hs   = req_i.aw_valid && resp_o.aw_ready;
      w_hs    = req_i.w_valid && resp_o.w_ready;
      b_hs    = resp_o.b_valid && req_i.b_ready;
      ar_hs   = req_i.ar_valid && resp_o.ar_ready;
      r_hs    = resp_o.r_valid && req_i.r_ready;
      aw_s    = req_i.aw;
      w_s     = req_i.w;
      ar_s    = req_i.ar;
      stall_s = stall_en_i;
      @(posedge clk_i);
      #1;
      if (!rst_ni) begin
        resp_o  = '0;
        wr_busy = 1'b0;
      end else begin
        if (b_hs) begin
          resp_o.b_valid = 1'b0;
          wr_busy        = 1'b0;
        end
        if (aw_hs) begin
          aw_q      = aw_s;
          wr_addr   = aw_s.addr;
          wr_busy   = 1'b1;
          aw_len_o  = aw_s.len;
          aw_size_o = aw_s.size;
        end
        if (w_hs) begin
          wbase = wr_addr & ~addr_t'(7);
          for (int n = 0; n < WideStrbWidth; n++) begin
            if (w_s.strb[n]) begin
              mem[wbase[7:0] + 8'(n)] = w_s.data[8*n +: 8];
            end
          end
          wr_addr = step_addr(wr_addr, aw_q.size, aw_q.burst);
          if (w_s.last) begin
            resp_o.b_valid = 1'b1;
            resp_o.b.id    = aw_q.id;
            resp_o.b.resp  = '0;
          end
        end
        if (r_hs) begin
          if (resp_o.r.last) begin
            resp_o.r_valid = 1'b0;
          end else begin
            rd_addr = step_addr(rd_addr, ar_q.size, ar_q.burst);
            rd_cnt  = rd_cnt + 8'd1;
            load_r_beat();
          end
        end
        if (ar_hs) begin
          ar_q           = ar_s;
          rd_addr        = ar_s.addr;
          rd_cnt         = '0;
          ar_len_o       = ar_s.len;
          ar_size_o      = ar_s.size;
          load_r_beat();
          resp_o.r_valid = 1'b1;
        end
        resp_o.aw_ready = !wr_busy && !random_stall();
        resp_o.w_ready  = wr_busy && !resp_o.b_valid && !random_stall();
        resp_o.ar_ready = !resp_o.r_valid && !random_stall();
      end
    end
  end

endmodule

`default_nettype wire

/* tb_dw_upsizer.sv */
// ***************************************************************************
// Data width upsizer testbench
// ***************************************************************************
`default_nettype none

module tb_dw_upsizer
  import dw_upsizer_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct {
    string      name;
    bit         wr;
    addr_t      addr;
    len_t       len;
    size_t      size;
    burst_t     burst;
    cache_t     cache;
    logic [7:0] base;
    len_t       exp_len;
    size_t      exp_size;
  } row_t;

  logic         clk;
  logic         rst_n;
  logic         stall_en;
  narrow_req_t  slv_req;
  narrow_resp_t slv_resp;
  wide_req_t    mst_req;
  wide_resp_t   mst_resp;
  len_t         aw_len;
  size_t        aw_size;
  len_t         ar_len;
  size_t        ar_size;

  row_t         rows[$];
  logic [7:0]   ref_mem [256];
  int           data_errs;
  int           ctrl_errs;
  int           cycles;
  int           limit;

  dw_upsizer_top dut0 (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp)
  );

  tb_wide_mem i_mem (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .stall_en_i (stall_en),
    .req_i      (mst_req),
    .resp_o     (mst_resp),
    .aw_len_o   (aw_len),
    .aw_size_o  (aw_size),
    .ar_len_o   (ar_len),
    .ar_size_o  (ar_size)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, a transfer never completed", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic add_row(input string name, input bit wr, input addr_t addr, input len_t len,
                         input size_t size, input burst_t burst, input cache_t cache,
                         input logic [7:0] base, input len_t exp_len, input size_t exp_size);
    row_t r;
    r.name     = name;
    r.wr       = wr;
    r.addr     = addr;
    r.len      = len;
    r.size     = size;
    r.burst    = burst;
    r.cache    = cache;
    r.base     = base;
    r.exp_len  = exp_len;
    r.exp_size = exp_size;
    rows.push_back(r);
  endtask

  task automatic next_drive_point();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_equal(input string name, input string what, input int exp, input int act);
    if (act != exp) begin
      ctrl_errs++;
      $display("[ERROR] %s: %s expected %0d actual %0d", name, what, exp, act);
    end
  endtask

  task automatic drive_ax(output ax_chan_t ax, input row_t r, input id_t id);
    ax.id    = id;
    ax.addr  = r.addr;
    ax.len   = r.len;
    ax.size  = r.size;
    ax.burst = r.burst;
    ax.cache = r.cache;
  endtask

  task automatic run_write(input row_t r, input id_t id, input logic [7:0] base);
    addr_t      a;
    addr_t      first;
    logic [7:0] val;
    int         lo;
    int         hi;
    logic       hs;
    a   = r.addr;
    val = base;
    drive_ax(slv_req.aw, r, id);
    slv_req.aw_valid = 1'b1;
    do begin
      @(negedge clk);
      hs = slv_resp.aw_ready;
      next_drive_point();
    end while (!hs);
    slv_req.aw_valid = 1'b0;
    for (int k = 0; k <= int'(r.len); k++) begin
      // Incrementing bytes on the lanes that the beat address covers
      first     = a & ~((addr_t'(1) << r.size) - addr_t'(1));
      lo        = int'(a[1:0]);
      hi        = int'(first[1:0]) + (1 << r.size);
      slv_req.w = '0;
      for (int n = lo; n < hi; n++) begin
        slv_req.w.data[8*n +: 8] = val;
        slv_req.w.strb[n]        = 1'b1;
        ref_mem[(a[7:0] & 8'hFC) + 8'(n)] = val;
        val++;
      end
      slv_req.w.last  = (k == int'(r.len));
      slv_req.w_valid = 1'b1;
      do begin
        @(negedge clk);
        hs = slv_resp.w_ready;
        next_drive_point();
      end while (!hs);
      if (r.burst == BurstIncr) begin
        a = first + (addr_t'(1) << r.size);
      end
    end
    slv_req.w_valid = 1'b0;
    do begin
      @(negedge clk);
      hs = slv_resp.b_valid;
      if (hs) begin
        expect_equal(r.name, "B id", int'(id), int'(slv_resp.b.id));
        expect_equal(r.name, "B resp", 0, int'(slv_resp.b.resp));
      end
      next_drive_point();
    end while (!hs);
    expect_equal(r.name, "wide AW len", int'(r.exp_len), int'(aw_len));
    expect_equal(r.name, "wide AW size", int'(r.exp_size), int'(aw_size));
  endtask

  task automatic run_read(input row_t r, input id_t id);
    addr_t        a;
    addr_t        first;
    narrow_data_t exp;
    narrow_data_t mask;
    int           lo;
    int           hi;
    int           beats;
    logic         hs;
    logic         done;
    drive_ax(slv_req.ar, r, id);
    slv_req.ar_valid = 1'b1;
    do begin
      @(negedge clk);
      hs = slv_resp.ar_ready;
      next_drive_point();
    end while (!hs);
    slv_req.ar_valid = 1'b0;
    a     = r.addr;
    beats = 0;
    done  = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (slv_resp.r_valid) begin
        first = a & ~((addr_t'(1) << r.size) - addr_t'(1));
        lo    = int'(a[1:0]);
        hi    = int'(first[1:0]) + (1 << r.size);
        exp   = '0;
        mask  = '0;
        for (int n = lo; n < hi; n++) begin
          exp[8*n +: 8]  = ref_mem[(a[7:0] & 8'hFC) + 8'(n)];
          mask[8*n +: 8] = 8'hFF;
        end
        if ((slv_resp.r.data & mask) !== exp) begin
          data_errs++;
          $display("[ERROR] %s: beat %0d data expected %h actual %h", r.name, beats, exp,
                   slv_resp.r.data & mask);
        end
        expect_equal(r.name, "R last", int'(beats == int'(r.len)), int'(slv_resp.r.last));
        expect_equal(r.name, "R id", int'(id), int'(slv_resp.r.id));
        expect_equal(r.name, "R resp", 0, int'(slv_resp.r.resp));
        done = slv_resp.r.last || (beats == int'(r.len));
        beats++;
        if (r.burst == BurstIncr) begin
          a = first + (addr_t'(1) << r.size);
        end
      end
      next_drive_point();
    end
    expect_equal(r.name, "narrow R beats", int'(r.len) + 1, beats);
    @(negedge clk);
    if (slv_resp.r_valid) begin
      ctrl_errs++;
      $display("[ERROR] %s: an extra narrow R beat followed the last one", r.name);
    end
    next_drive_point();
    expect_equal(r.name, "wide AR len", int'(r.exp_len), int'(ar_len));
    expect_equal(r.name, "wide AR size", int'(r.exp_size), int'(ar_size));
  endtask

  initial begin
    slv_req         = '0;
    slv_req.b_ready = 1'b1;
    slv_req.r_ready = 1'b1;
    rst_n           = 1'b0;
    stall_en        = 1'b0;
    data_errs       = 0;
    ctrl_errs       = 0;
    cycles          = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 8'(i) ^ 8'hA5;
    end

    // Name, write, addr, len, size, burst, cache, base byte, wide len, wide size
    add_row("wr_single0", 1'b1, 16'h0000, 8'd0, 3'd2, BurstIncr, 4'h2, 8'h10, 8'd0, 3'd2);
    add_row("wr_single4", 1'b1, 16'h0004, 8'd0, 3'd2, BurstIncr, 4'h2, 8'h20, 8'd0, 3'd2);
    add_row("wr_single6", 1'b1, 16'h0006, 8'd0, 3'd2, BurstIncr, 4'h2, 8'h30, 8'd0, 3'd2);
    add_row("rd_single0", 1'b0, 16'h0000, 8'd0, 3'd2, BurstIncr, 4'h2, 8'h00, 8'd0, 3'd2);
    add_row("rd_single4", 1'b0, 16'h0004, 8'd0, 3'd2, BurstIncr, 4'h2, 8'h00, 8'd0, 3'd2);
    add_row("rd_single6", 1'b0, 16'h0006, 8'd0, 3'd2, BurstIncr, 4'h2, 8'h00, 8'd0, 3'd2);
    add_row("wr_upsize", 1'b1, 16'h0020, 8'd3, 3'd2, BurstIncr, 4'h2, 8'h40, 8'd1, 3'd3);
    add_row("rd_upsize", 1'b0, 16'h0020, 8'd3, 3'd2, BurstIncr, 4'h2, 8'h00, 8'd1, 3'd3);
    add_row("wr_nomod", 1'b1, 16'h0040, 8'd3, 3'd2, BurstIncr, 4'h0, 8'h50, 8'd3, 3'd2);
    add_row("rd_nomod", 1'b0, 16'h0040, 8'd3, 3'd2, BurstIncr, 4'h0, 8'h00, 8'd3, 3'd2);
    add_row("wr_fixed", 1'b1, 16'h0060, 8'd2, 3'd2, BurstFixed, 4'h2, 8'h60, 8'd2, 3'd2);
    add_row("rd_fixed", 1'b0, 16'h0060, 8'd2, 3'd2, BurstFixed, 4'h2, 8'h00, 8'd2, 3'd2);
    add_row("wr_long", 1'b1, 16'h0080, 8'd7, 3'd2, BurstIncr, 4'h3, 8'h70, 8'd3, 3'd3);
    add_row("rd_long", 1'b0, 16'h0080, 8'd7, 3'd2, BurstIncr, 4'h3, 8'h00, 8'd3, 3'd3);
    add_row("wr_unalign", 1'b1, 16'h00A4, 8'd2, 3'd2, BurstIncr, 4'h2, 8'h90, 8'd1, 3'd3);
    add_row("rd_unalign", 1'b0, 16'h00A4, 8'd2, 3'd2, BurstIncr, 4'h2, 8'h00, 8'd1, 3'd3);

    // Both passes over the table
    limit = 2 * rows.size() * 64;

    repeat (2) @(posedge clk);
    @(negedge clk);
    if (mst_req.aw_valid || mst_req.w_valid || mst_req.ar_valid || slv_resp.r_valid ||
        slv_resp.aw_ready || slv_resp.ar_ready) begin
      ctrl_errs++;
      $display("[ERROR] reset: a valid or ready output is high during reset");
    end
    repeat (6) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Second pass adds wide-side stalls and fresh data
    for (int pass = 0; pass < 2; pass++) begin
      stall_en = (pass == 1);
      foreach (rows[i]) begin
        if (rows[i].wr) begin
          run_write(rows[i], id_t'(i), rows[i].base + 8'(pass * 8'h80));
        end else begin
          run_read(rows[i], id_t'(i));
        end
      end
    end

    $display("Summary: %0d data errors, %0d control errors", data_errs, ctrl_errs);
    if (data_errs + ctrl_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
dw_upsizer_pkg.sv
dw_burst_planner.sv
dw_write_upsizer.sv
dw_read_upsizer.sv
dw_upsizer_top.sv
tb_wide_mem.sv
tb_dw_upsizer.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
TOP       ?= tb_dw_upsizer
FILELIST  ?= filelist.f
LOG       ?= sim.log
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
